// ==== hdl/dlc_pkg.sv ====
// Shared sizes of the level-crossing encoder
// Static configuration struct, stream struct and encoder FSM states
package dlc_pkg;

  // Sample, level and packet width
  localparam int SAMPLE_W = 16;

  // Entries per FIFO, also the input credits upstream starts with
  localparam int FIFO_DEPTH = 4;

  // FIFO item count and output credit counter
  localparam int CNT_W = 3;

  // FIFO pointer width, depth is a power of two
  localparam int PTR_W = $clog2(FIFO_DEPTH);

  // Static configuration, held from reset to end of a run
  typedef struct packed {
    logic [3:0] log_wl;     // Level width is 2**log_wl
    logic [3:0] dlvl_bits;  // Delta-level field width, 2..8
    logic [4:0] dt_bits;    // Delta-time width, 2..12
    logic       twos_comp;  // 1: signed chunk, 0: sign-magnitude
  } dlc_cfg_t;

  // Single-word stream beat, used on both sides of the DUT
  typedef struct packed {
    logic                valid;
    logic [SAMPLE_W-1:0] data;
  } dlc_stream_t;

  // Encoder FSM
  // RUN consumes samples, the others emit extra packets
  typedef enum logic [1:0] {
    RUN,       // One sample per cycle
    DLVL_OVF,  // Level jump split into more chunks
    DT_OVF     // Delta-time counter wrapped, send marker packet
  } dlc_state_t;

endpackage

// ==== hdl/dlc_fifo.sv ====
// Synchronous FIFO with registered storage
// Full and empty flags from an item count, no fall-through
module dlc_fifo import dlc_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                push_i,
  input  logic [SAMPLE_W-1:0] data_i,
  input  logic                pop_i,
  output logic [SAMPLE_W-1:0] data_o,
  output logic                full_o,
  output logic                empty_o
);

  logic [SAMPLE_W-1:0] mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0]    wr_ptr_q;
  logic [PTR_W-1:0]    rd_ptr_q;
  logic [CNT_W-1:0]    count_q;
  logic                do_push;
  logic                do_pop;

  assign full_o  = (count_q == CNT_W'(FIFO_DEPTH));
  assign empty_o = (count_q == '0);

  // Illegal requests are dropped
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign data_o = mem_q[rd_ptr_q];  // Head of queue

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Both or neither
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// ==== hdl/dlc_level_detect.sv ====
// Level quantizer and current-level register
// Signed delta against the current level, its magnitude and sign
// Crossing flag when the sample sits on another level
module dlc_level_detect import dlc_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  dlc_cfg_t            cfg_i,
  input  logic [SAMPLE_W-1:0] sample_i,
  input  logic                take_i,
  output logic [SAMPLE_W-1:0] delta_abs_o,
  output logic                dir_o,
  output logic                crossing_o
);

  logic signed [SAMPLE_W-1:0] level;       // Level of the head sample
  logic signed [SAMPLE_W-1:0] curr_lvl_q;  // Last level that was sent
  logic signed [SAMPLE_W-1:0] delta;

  // Arithmetic shift keeps the sign of the sample
  assign level = $signed(sample_i) >>> cfg_i.log_wl;

  // Wraps at 16 bits like the packet fields
  assign delta = level - curr_lvl_q;

  assign dir_o      = delta[SAMPLE_W-1];  // 1 when going down
  assign crossing_o = (delta != '0);

  // Magnitude, two's-complement negate when negative
  always_comb begin
    if (delta[SAMPLE_W-1]) begin
      delta_abs_o = ~delta + 1'b1;
    end else begin
      delta_abs_o = delta;
    end
  end

  // Level moves only on a consumed crossing
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      curr_lvl_q <= '0;
    end else if (take_i && crossing_o) begin
      curr_lvl_q <= level;
    end
  end

endmodule

// ==== hdl/dlc_encoder.sv ====
// Level-crossing encoder FSM
// Delta-time counter, overflow remainder and latched direction
// Packet word in sign-magnitude or two's-complement format
module dlc_encoder import dlc_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  dlc_cfg_t            cfg_i,
  input  logic                in_empty_i,
  input  logic                out_full_i,
  input  logic [SAMPLE_W-1:0] delta_abs_i,
  input  logic                dir_i,
  input  logic                crossing_i,
  output logic                pop_o,
  output logic                take_o,
  output logic                push_o,
  output logic [SAMPLE_W-1:0] pkt_o
);

  dlc_state_t state_q;
  dlc_state_t state_d;

  logic [SAMPLE_W-1:0] c_q;    // Samples since last packet
  logic [SAMPLE_W-1:0] c_d;
  logic [SAMPLE_W-1:0] rem_q;  // Jump left to send
  logic [SAMPLE_W-1:0] rem_d;
  logic                dir_q;  // Sign of the split jump
  logic                dir_d;

  logic [SAMPLE_W-1:0] max_mag;    // Largest chunk M
  logic [SAMPLE_W-1:0] dt_mask;
  logic [SAMPLE_W-1:0] dlvl_mask;  // Low field of the packet

  // Fields of the packet pushed this cycle
  logic [SAMPLE_W-1:0] pkt_dt;
  logic                pkt_dir;
  logic [SAMPLE_W-1:0] pkt_mag;
  logic [SAMPLE_W-1:0] dt_dir;     // Upper part before the shift
  logic [SAMPLE_W-1:0] field;      // Low part, already masked

  // Masks from bit counts
  assign dlvl_mask = (SAMPLE_W'(1) << cfg_i.dlvl_bits) - 1'b1;
  assign dt_mask   = (SAMPLE_W'(1) << cfg_i.dt_bits) - 1'b1;

  // Signed field loses one bit to the sign
  assign max_mag = cfg_i.twos_comp ?
                   (SAMPLE_W'(1) << (cfg_i.dlvl_bits - 4'd1)) - 1'b1 : dlvl_mask;

  // New samples only in RUN and with room for a packet
  assign pop_o  = (state_q == RUN) && !in_empty_i && !out_full_i;
  assign take_o = pop_o;  // Detector consumes what we pop

  always_comb begin
    state_d = state_q;
    c_d     = c_q;
    rem_d   = rem_q;
    dir_d   = dir_q;
    push_o  = 1'b0;
    pkt_dt  = '0;
    pkt_dir = 1'b0;
    pkt_mag = '0;
    case (state_q)
      RUN: begin
        if (pop_o && crossing_i) begin
          push_o  = 1'b1;      // Same cycle as the pop
          pkt_dt  = c_q;       // First chunk carries the time
          pkt_dir = dir_i;
          c_d     = SAMPLE_W'(1);
          if (delta_abs_i > max_mag) begin
            pkt_mag = max_mag;
            rem_d   = delta_abs_i - max_mag;
            dir_d   = dir_i;
            state_d = DLVL_OVF;
          end else begin
            pkt_mag = delta_abs_i;
          end
        end else if (pop_o) begin
          if (c_q == dt_mask) begin
            state_d = DT_OVF;  // Marker goes out next
          end else begin
            c_d = c_q + 1'b1;
          end
        end
      end
      DLVL_OVF: begin
        if (!out_full_i) begin
          push_o  = 1'b1;
          pkt_dir = dir_q;     // dt stays 0
          if (rem_q > max_mag) begin
            pkt_mag = max_mag;
            rem_d   = rem_q - max_mag;
          end else begin
            pkt_mag = rem_q;   // Last chunk
            rem_d   = '0;
            state_d = RUN;
          end
        end
      end
      DT_OVF: begin
        if (!out_full_i) begin
          push_o  = 1'b1;
          pkt_dt  = dt_mask;   // Zero delta, full dt
          c_d     = SAMPLE_W'(1);
          state_d = RUN;
        end
      end
      default: state_d = RUN;
    endcase
  end

  // Packet word, truncated to SAMPLE_W
  always_comb begin
    if (cfg_i.twos_comp) begin
      dt_dir = pkt_dt;
      field  = (pkt_dir ? (~pkt_mag + 1'b1) : pkt_mag) & dlvl_mask;
    end else begin
      dt_dir = {pkt_dt[SAMPLE_W-2:0], pkt_dir};  // Direction just above the field
      field  = pkt_mag & dlvl_mask;
    end
    pkt_o = (dt_dir << cfg_i.dlvl_bits) | field;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RUN;
      c_q     <= '0;
      rem_q   <= '0;
      dir_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      c_q     <= c_d;
      rem_q   <= rem_d;
      dir_q   <= dir_d;
    end
  end

endmodule

// ==== hdl/dlc_credit_tx.sv ====
// Output credit counter
// Drains the output FIFO, one registered packet per credit
module dlc_credit_tx import dlc_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                fifo_empty_i,
  input  logic [SAMPLE_W-1:0] fifo_data_i,
  input  logic                out_credit_i,
  output logic                fifo_pop_o,
  output dlc_stream_t         out_o
);

  logic [CNT_W-1:0]    credit_q;  // Packets downstream can take
  logic                credit_add;
  logic                valid_q;
  logic [SAMPLE_W-1:0] data_q;

  // Saturate at the counter top
  assign credit_add = out_credit_i && !(&credit_q);
  assign fifo_pop_o = (credit_q != '0) && !fifo_empty_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= '0;  // Downstream grants first
      valid_q  <= 1'b0;
    end else begin
      valid_q <= fifo_pop_o;
      case ({credit_add, fifo_pop_o})
        2'b10:   credit_q <= credit_q + 1'b1;
        2'b01:   credit_q <= credit_q - 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (fifo_pop_o) data_q <= fifo_data_i;
  end

  assign out_o.valid = valid_q;
  assign out_o.data  = data_q;

endmodule

// ==== hdl/dlc_top.sv ====
// Level-crossing encoder top
// Input and output FIFOs, detector, encoder and output credit logic
// Input credit returned one cycle after each pop
module dlc_top import dlc_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  dlc_cfg_t    cfg_i,
  input  dlc_stream_t in_i,
  output logic        in_credit_o,
  output dlc_stream_t out_o,
  input  logic        out_credit_i
);

  logic [SAMPLE_W-1:0] sample;       // Head of input FIFO
  logic                in_empty;
  logic                enc_pop;
  logic                enc_take;
  logic [SAMPLE_W-1:0] delta_abs;
  logic                dir;
  logic                crossing;
  logic                enc_push;
  logic [SAMPLE_W-1:0] pkt;
  logic                out_full;
  logic                out_empty;
  logic [SAMPLE_W-1:0] out_head;
  logic                tx_pop;

  dlc_fifo in_fifo (
    .clk_i, .rst_ni,
    .push_i (in_i.valid), .data_i (in_i.data), .pop_i (enc_pop),
    .data_o (sample), .full_o (), .empty_o (in_empty)  // Credits prevent overflow
  );

  dlc_level_detect level_detect_inst (
    .clk_i, .rst_ni, .cfg_i,
    .sample_i (sample), .take_i (enc_take),
    .delta_abs_o (delta_abs), .dir_o (dir), .crossing_o (crossing)
  );

  dlc_encoder encoder_inst (
    .clk_i, .rst_ni, .cfg_i,
    .in_empty_i (in_empty), .out_full_i (out_full),
    .delta_abs_i (delta_abs), .dir_i (dir), .crossing_i (crossing),
    .pop_o (enc_pop), .take_o (enc_take), .push_o (enc_push), .pkt_o (pkt)
  );

  dlc_fifo out_fifo (
    .clk_i, .rst_ni,
    .push_i (enc_push), .data_i (pkt), .pop_i (tx_pop),
    .data_o (out_head), .full_o (out_full), .empty_o (out_empty)
  );

  dlc_credit_tx credit_tx_inst (
    .clk_i, .rst_ni,
    .fifo_empty_i (out_empty), .fifo_data_i (out_head), .out_credit_i,
    .fifo_pop_o (tx_pop), .out_o
  );

  // Freed input slot goes back upstream
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) in_credit_o <= 1'b0;
    else         in_credit_o <= enc_pop;
  end

endmodule

// ==== tb/dlc_properties.sv ====
// Concurrent assertions bound into the encoder top
// Output credit use, legal pops and the exit from DT_OVF
// FIFO fill and downstream credits counted on the side
module dlc_properties import dlc_pkg::*; (
  input logic       clk_i,
  input logic       rst_ni,
  input logic       out_valid_i,
  input logic       out_credit_i,
  input logic       in_valid_i,
  input logic       pop_i,
  input logic       push_i,
  input logic       tx_pop_i,
  input dlc_state_t state_i
);

  int fail_count = 0;  // Read by the testbench summary
  int granted;         // Credits handed out by downstream, not yet used
  int in_occ;          // Samples sitting in the input FIFO
  int out_occ;         // Packets sitting in the output FIFO

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      granted <= 0;
      in_occ  <= 0;
      out_occ <= 0;
    end else begin
      granted <= granted + int'(out_credit_i) - int'(out_valid_i);
      in_occ  <= in_occ + int'(in_valid_i) - int'(pop_i);
      out_occ <= out_occ + int'(push_i) - int'(tx_pop_i);
    end
  end

  // Every packet needs a credit granted in an earlier cycle
  valid_needs_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_i |-> granted > 0)
    else begin
      fail_count++;
      $error("Output packet sent without a credit");
    end

  pop_is_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> (in_occ > 0) && (out_occ < FIFO_DEPTH))
    else begin
      fail_count++;
      $error("Pop with input FIFO empty or output FIFO full");
    end

  // Marker packet must go out before RUN resumes
  dt_ovf_exit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_i == DT_OVF) && !push_i |=> state_i == DT_OVF)
    else begin
      fail_count++;
      $error("DT_OVF left without pushing a packet");
    end

endmodule

bind dlc_top dlc_properties properties_inst (
  .clk_i (clk_i), .rst_ni (rst_ni), .out_valid_i (out_o.valid),
  .out_credit_i (out_credit_i), .in_valid_i (in_i.valid), .pop_i (enc_pop),
  .push_i (enc_push), .tx_pop_i (tx_pop), .state_i (encoder_inst.state_q)
);

// ==== tb/dlc_checker.sv ====
// Reference model of the level-crossing encoding rule
// Expected-packet queue and comparison against the DUT output
// Counts of mismatched, missing and unexpected packets
module dlc_checker import dlc_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  dlc_cfg_t    cfg_i,
  input  dlc_stream_t in_i,
  input  dlc_stream_t out_i,
  output int          pending_o,
  output int          mismatch_o,
  output int          missing_o,
  output int          unexpected_o
);

  logic [SAMPLE_W-1:0] exp_q [$];  // Packets still to come out
  logic [SAMPLE_W-1:0] word;
  int model_c   = 0;               // Samples since last packet
  int model_lvl = 0;               // Level last sent
  int pending_cnt    = 0;
  int mismatch_cnt   = 0;
  int missing_cnt    = 0;
  int unexpected_cnt = 0;

  assign pending_o    = pending_cnt;
  assign mismatch_o   = mismatch_cnt;
  assign missing_o    = missing_cnt;
  assign unexpected_o = unexpected_cnt;

  // One packet word from its fields, cut to 16 bits
  function automatic logic [SAMPLE_W-1:0] pack_word(int dt, bit neg, int mag);
    int b;
    int mask;
    int w;
    b    = int'(cfg_i.dlvl_bits);
    mask = (1 << b) - 1;
    if (cfg_i.twos_comp) begin
      w = (dt << b) | ((neg ? -mag : mag) & mask);  // Signed chunk, no sign bit
    end else begin
      w = (((dt << 1) | int'(neg)) << b) | (mag & mask);
    end
    return w[SAMPLE_W-1:0];
  endfunction

  // Applies the encoding rule to one accepted sample
  function automatic void model_sample(logic [SAMPLE_W-1:0] s);
    int lvl_new;
    int d;
    int r;
    int m;
    int dtm;
    int dt;
    bit neg;
    lvl_new = int'($signed(s)) >>> cfg_i.log_wl;
    d       = lvl_new - model_lvl;
    if (cfg_i.twos_comp) m = (1 << (int'(cfg_i.dlvl_bits) - 1)) - 1;
    else                 m = (1 << int'(cfg_i.dlvl_bits)) - 1;
    dtm = (1 << int'(cfg_i.dt_bits)) - 1;
    if (d == 0) begin
      if (model_c == dtm) begin
        exp_q.push_back(pack_word(dtm, 1'b0, 0));  // Time marker
        model_c = 1;
      end else begin
        model_c++;
      end
    end else begin
      model_lvl = lvl_new;
      neg = (d < 0);
      r   = neg ? -d : d;
      dt  = model_c;         // Only the first chunk
      while (r > m) begin
        exp_q.push_back(pack_word(dt, neg, m));
        r  = r - m;
        dt = 0;
      end
      exp_q.push_back(pack_word(dt, neg, r));
      model_c = 1;
    end
  endfunction

  // Output first, then the new input, both on the same edge
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      while (exp_q.size() > 0) begin
        word = exp_q.pop_front();
        missing_cnt++;
        $display("Missing packet: %h was expected but never came out (time %0t)",
                 word, $time);
      end
      model_c   = 0;
      model_lvl = 0;
    end else begin
      if (out_i.valid) begin
        if (exp_q.size() == 0) begin
          unexpected_cnt++;
          $display("Unexpected packet %h came out at time %0t with none expected",
                   out_i.data, $time);
        end else begin
          word = exp_q.pop_front();
          if (out_i.data !== word) begin
            mismatch_cnt++;
            $display("FAIL at %0t: packet %h does not match expected %h",
                     $time, out_i.data, word);
          end
        end
      end
      if (in_i.valid) model_sample(in_i.data);  // FIFO never full under credits
    end
    pending_cnt = exp_q.size();
  end

endmodule

// ==== tb/dlc_tb.sv ====
// Testbench top of the level-crossing encoder
// Clock, reset, stimulus phases, input and output credits, watchdog
module dlc_tb import dlc_pkg::*; ();

  localparam int TOTAL_SAMPLES   = 240;  // Sum over all phases
  localparam int WATCHDOG_CYCLES = TOTAL_SAMPLES * 40 + 2000;
  localparam int DRAIN_LIMIT     = 1000; // Cycles to empty the DUT

  logic        clk;
  logic        rst_n;
  dlc_cfg_t    cfg;
  dlc_stream_t in_stim;
  logic        in_credit;
  dlc_stream_t out_word;
  logic        out_credit;

  int credits;           // Input credits upstream holds
  int pushes;            // Samples sent this phase
  int credit_pulses;     // in_credit_o pulses this phase
  int grant_div = 2;     // One output credit in grant_div cycles
  int credit_errs = 0;
  int pending;
  int mismatches;
  int missing;
  int unexpected;

  dlc_top dlc_top_inst (
    .clk_i (clk), .rst_ni (rst_n), .cfg_i (cfg), .in_i (in_stim),
    .in_credit_o (in_credit), .out_o (out_word), .out_credit_i (out_credit)
  );

  dlc_checker checker_inst (
    .clk_i (clk), .rst_ni (rst_n), .cfg_i (cfg), .in_i (in_stim), .out_i (out_word),
    .pending_o (pending), .mismatch_o (mismatches), .missing_o (missing),
    .unexpected_o (unexpected)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Upstream side of the input credit loop
  always @(posedge clk) begin
    if (!rst_n) begin
      credits       = FIFO_DEPTH;
      pushes        = 0;
      credit_pulses = 0;
    end else begin
      if (in_credit) begin
        credits++;
        credit_pulses++;
      end
      if (in_stim.valid) begin
        credits--;
        pushes++;
      end
    end
  end

  function automatic dlc_cfg_t make_cfg(int lw, int db, int dtb, bit tc);
    dlc_cfg_t c;
    c.log_wl    = 4'(lw);
    c.dlvl_bits = 4'(db);
    c.dt_bits   = 5'(dtb);
    c.twos_comp = tc;
    return c;
  endfunction

  // One falling edge: sample if a credit is held, random output grant
  task automatic drive_cycle(input logic push_req, input logic [SAMPLE_W-1:0] data,
                             output logic pushed);
    @(negedge clk);
    pushed        = push_req && (credits > 0);
    in_stim.valid = pushed;
    in_stim.data  = pushed ? data : '0;
    out_credit    = (($urandom % grant_div) == 0);
  endtask

  task automatic send_sample(input logic [SAMPLE_W-1:0] data);
    logic pushed;
    do drive_cycle(1'b1, data, pushed); while (!pushed);
  endtask

  task automatic apply_reset(input dlc_cfg_t new_cfg);
    @(negedge clk);
    rst_n      = 1'b0;
    cfg        = new_cfg;
    in_stim    = '0;
    out_credit = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
  endtask

  // Random walk over levels, low bits random inside the level
  task automatic run_phase(input dlc_cfg_t new_cfg, input int n, input int start_lvl,
                           input int max_step, input int div);
    int lvl;
    int step;
    int scale;
    int s;
    int waited;
    logic pushed;
    apply_reset(new_cfg);
    grant_div = div;
    lvl       = start_lvl;
    scale     = 1 << new_cfg.log_wl;
    for (int i = 0; i < n; i++) begin
      step = (max_step > 0) ? int'($urandom % (2 * max_step + 1)) - max_step : 0;
      lvl  = lvl + step;
      if (lvl > 100) lvl = 100;
      if (lvl < -100) lvl = -100;
      s = lvl * scale + int'($urandom % scale);
      send_sample(s[SAMPLE_W-1:0]);
    end
    waited = 0;
    do begin
      drive_cycle(1'b0, '0, pushed);
      waited++;
    end while ((pending != 0 || credit_pulses != pushes) && waited < DRAIN_LIMIT);
    repeat (20) drive_cycle(1'b0, '0, pushed);  // Catch late extra packets
    if (credit_pulses != pushes) begin
      credit_errs++;
      $display("Input credits wrong: %0d pulses returned for %0d samples pushed",
               credit_pulses, pushes);
    end
  endtask

  initial begin
    int total;
    void'($urandom(32'hb697_3425));
    rst_n      = 1'b0;
    cfg        = '0;
    in_stim    = '0;
    out_credit = 1'b0;
    run_phase(make_cfg(4, 4, 6, 1'b0), 60, 0, 3, 2);   // Sign-magnitude, small steps
    run_phase(make_cfg(3, 5, 5, 1'b1), 60, 0, 20, 2);  // Two's complement, some splits
    run_phase(make_cfg(4, 4, 3, 1'b0), 40, 3, 0, 2);   // Flat, dt wraps at 7
    run_phase(make_cfg(2, 2, 6, 1'b0), 30, 0, 20, 2);  // Large jumps, M is 3
    run_phase(make_cfg(4, 3, 4, 1'b1), 50, 0, 2, 8);   // Sparse output credits
    apply_reset(cfg);  // Leftover expected packets count as missing
    @(negedge clk);
    total = mismatches + missing + unexpected + credit_errs +
            dlc_top_inst.properties_inst.fail_count;
    $display("Summary: %0d mismatched, %0d missing, %0d unexpected, %0d credit, %0d assertion",
             mismatches, missing, unexpected, credit_errs,
             dlc_top_inst.properties_inst.fail_count);
    if (total == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock periods", WATCHDOG_CYCLES);
    $display("Errors found");
    $finish;
  end

endmodule

// ==== filelist.f ====
hdl/dlc_pkg.sv
hdl/dlc_fifo.sv
hdl/dlc_level_detect.sv
hdl/dlc_encoder.sv
hdl/dlc_credit_tx.sv
hdl/dlc_top.sv
tb/dlc_properties.sv
tb/dlc_checker.sv
tb/dlc_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= dlc_tb
FILELIST  ?= filelist.f

.PHONY: sim clean

# Build, run, and pass only if the pass line is printed
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
